/* rtl/adc_defs.svh */
`ifndef ADC_DEFS_SVH
`define ADC_DEFS_SVH

// sample and channel geometry
`define W_DATA 18	// bits per sample on each data line
`define N_ADC 6		// active adc channels
`define W_CHAN 3	// channel field in a frame

// channel numbers 6 and 7 fit the field but are rejected by the receiver

// oversample filter
`define OSR 4		// samples summed per result
`define W_SUM (`W_DATA + 2)	// room for OSR samples without wrap

// buffering between sync stage and filter
`define FIFO_DEPTH 8	// sample_fifo entries
`define N_CREDITS 2	// filter queue depth, also the starting credit count

`endif

/* rtl/adc_pkg.sv */
`default_nettype none

`include "adc_defs.svh"

package adc_pkg;

	//////////////////////////////
	// state encodings
	//////////////////////////////

	// serial receiver, adc_sclk domain
	typedef enum logic [1:0] {
		rx_idle,	// waiting for adc_frame
		rx_chan,	// shifting channel bits from line a
		rx_data,	// shifting sample bits from both lines
		rx_hold		// data_valid high for two sclk cycles
	} rx_state_t;

	// strobe handshake, system clock domain
	typedef enum logic [1:0] {
		st_wait_pe,	// wait for synced strobe to rise
		st_send,	// one cycle push
		st_wait_ne	// wait for synced strobe to fall
	} sync_state_t;

	// accumulator word
	typedef logic [`W_SUM-1:0] sum_t;

endpackage

`default_nettype wire

/* rtl/adc_frame_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module adc_frame_rx (
	input  logic			adc_sclk,	// adc bit clock
	input  logic			reset_in,
	input  logic			adc_frame,	// frame start marker
	input  logic			adc_sdata_a,
	input  logic			adc_sdata_b,
	output logic [`N_ADC-1:0]	data_valid,	// one-hot per channel
	output logic [`W_DATA-1:0]	data_a,
	output logic [`W_DATA-1:0]	data_b
);
	import adc_pkg::*;

	localparam int W_BIT = $clog2(`W_DATA);	// wide enough for the data bit count

	rx_state_t		state;
	logic [W_BIT-1:0]	bit_cnt;	// bits taken in current field
	logic [`W_CHAN-1:0]	chan_sr;	// channel shift register
	logic [`W_DATA-1:0]	shift_a;
	logic [`W_DATA-1:0]	shift_b;
	logic [`W_CHAN-1:0]	chan_nxt;
	logic [`W_DATA-1:0]	shift_a_nxt;
	logic [`W_DATA-1:0]	shift_b_nxt;
	logic			chan_shift;	// channel bit on this edge
	logic			last_bit;	// last sample bit on this edge

	// msb first on every field
	assign chan_nxt = {chan_sr[`W_CHAN-2:0], adc_sdata_a};	// line b ignored here
	assign shift_a_nxt = {shift_a[`W_DATA-2:0], adc_sdata_a};
	assign shift_b_nxt = {shift_b[`W_DATA-2:0], adc_sdata_b};

	// the frame edge itself carries the first channel bit
	assign chan_shift = (state == rx_idle && adc_frame) || state == rx_chan;
	assign last_bit = (state == rx_data) && (bit_cnt == W_BIT'(`W_DATA-1));

	//////////////////////////////
	// control
	//////////////////////////////

	always_ff @(posedge adc_sclk or posedge reset_in) begin
		if (reset_in) begin
			state <= rx_idle;
			bit_cnt <= '0;
			data_valid <= '0;
		end else begin
			case (state)
				rx_idle: begin
					if (adc_frame) begin
						bit_cnt <= W_BIT'(1);	// first channel bit already in
						state <= rx_chan;
					end
				end
				rx_chan: begin
					if (bit_cnt == W_BIT'(`W_CHAN-1)) begin
						bit_cnt <= '0;
						state <= rx_data;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				rx_data: begin
					if (last_bit) begin
						bit_cnt <= '0;
						state <= rx_hold;
						// decode on the edge of the last bit
						if (chan_sr < `N_ADC)
							data_valid <= `N_ADC'(1) << chan_sr;
						else
							data_valid <= '0;	// bad channel, no strobe
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				rx_hold: begin
					if (bit_cnt == W_BIT'(1)) begin	// second hold cycle done
						bit_cnt <= '0;
						data_valid <= '0;
						state <= rx_idle;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	//////////////////////////////
	// shift and output registers
	//////////////////////////////

	always_ff @(posedge adc_sclk) begin
		if (chan_shift)
			chan_sr <= chan_nxt;
		if (state == rx_data) begin
			shift_a <= shift_a_nxt;
			shift_b <= shift_b_nxt;
		end
		if (last_bit) begin	// held until the next frame completes
			data_a <= shift_a_nxt;
			data_b <= shift_b_nxt;
		end
	end

endmodule

`default_nettype wire

/* rtl/adc_clk_sync.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module adc_clk_sync (
	input  logic			data_valid_rdc,	// system clock
	input  logic			reset_in,
	input  logic [`N_ADC-1:0]	data_valid,	// from receiver, sclk domain
	input  logic [`W_DATA-1:0]	data_a,
	input  logic [`W_DATA-1:0]	data_b,
	output logic			push,		// one system cycle per frame
	output logic [`N_ADC-1:0]	valid_vec,
	output logic [`W_DATA-1:0]	sync_a,
	output logic [`W_DATA-1:0]	sync_b
);
	import adc_pkg::*;

	logic			adc_strobe;	// any channel valid
	logic [`N_ADC-1:0]	vec_lat;	// latched valid vector
	logic			strobe_ff1;
	logic			strobe_ff2;	// synced strobe
	sync_state_t		state;
	sync_state_t		state_nxt;

	assign adc_strobe = |data_valid;

	//////////////////////////////
	// capture on strobe edge
	//////////////////////////////

	// data is stable long before the synced strobe reaches the fsm
	always_ff @(posedge adc_strobe or posedge reset_in) begin
		if (reset_in)
			vec_lat <= '0;
		else
			vec_lat <= data_valid;
	end

	always_ff @(posedge adc_strobe) begin
		sync_a <= data_a;
		sync_b <= data_b;
	end

	//////////////////////////////
	// system clock side
	//////////////////////////////

	// two flop synchronizer
	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in) begin
			strobe_ff1 <= 1'b0;
			strobe_ff2 <= 1'b0;
		end else begin
			strobe_ff1 <= adc_strobe;
			strobe_ff2 <= strobe_ff1;
		end
	end

	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in)
			state <= st_wait_pe;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;	// hold by default
		case (state)
			st_wait_pe: if (strobe_ff2) state_nxt = st_send;
			st_send: state_nxt = st_wait_ne;	// always one cycle
			st_wait_ne: if (!strobe_ff2) state_nxt = st_wait_pe;
			default: state_nxt = st_wait_pe;
		endcase
	end

	assign push = (state == st_send);
	assign valid_vec = vec_lat & {`N_ADC{push}};	// vector only with push

endmodule

`default_nettype wire

/* rtl/sample_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module sample_fifo (
	input  logic			data_valid_rdc,
	input  logic			reset_in,
	input  logic			push,
	input  logic [`N_ADC-1:0]	valid_vec,
	input  logic [`W_DATA-1:0]	sync_a,
	input  logic [`W_DATA-1:0]	sync_b,
	output logic			ent_valid,	// entry sent this cycle
	output logic [`N_ADC-1:0]	ent_vec,
	output logic [`W_DATA-1:0]	ent_a,
	output logic [`W_DATA-1:0]	ent_b,
	input  logic			credit_return,	// filter popped one
	output logic			overflow	// sticky
);
	localparam int W_PTR = ($clog2(`FIFO_DEPTH) > 0) ? $clog2(`FIFO_DEPTH) : 1;
	localparam int W_FILL = $clog2(`FIFO_DEPTH + 1);
	localparam int W_CRED = $clog2(`N_CREDITS + 1);

	logic [`N_ADC-1:0]	mem_vec [`FIFO_DEPTH];
	logic [`W_DATA-1:0]	mem_a [`FIFO_DEPTH];
	logic [`W_DATA-1:0]	mem_b [`FIFO_DEPTH];
	logic [W_PTR-1:0]	wr_ptr;
	logic [W_PTR-1:0]	rd_ptr;
	logic [W_FILL-1:0]	fill;
	logic [W_CRED-1:0]	credits;	// free slots in filter queue
	logic			full;
	logic			wr_en;
	logic			send;

	function automatic logic [W_PTR-1:0] ptr_inc(input logic [W_PTR-1:0] p);
		return (p == W_PTR'(`FIFO_DEPTH-1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (fill == W_FILL'(`FIFO_DEPTH));
	assign wr_en = push && !full;	// push into full fifo is lost
	assign send = (fill != '0) && (credits != '0);

	// head entry straight from storage
	assign ent_valid = send;
	assign ent_vec = mem_vec[rd_ptr];
	assign ent_a = mem_a[rd_ptr];
	assign ent_b = mem_b[rd_ptr];

	always_ff @(posedge data_valid_rdc) begin
		if (wr_en) begin
			mem_vec[wr_ptr] <= valid_vec;
			mem_a[wr_ptr] <= sync_a;
			mem_b[wr_ptr] <= sync_b;
		end
	end

	//////////////////////////////
	// pointers, fill, credits
	//////////////////////////////

	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			credits <= W_CRED'(`N_CREDITS);	// filter queue starts empty
			overflow <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= ptr_inc(wr_ptr);
			if (send)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({wr_en, send})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: ;	// both or neither
			endcase
			case ({send, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: ;
			endcase
			if (push && full)
				overflow <= 1'b1;	// held until reset
		end
	end

endmodule

`default_nettype wire

/* rtl/oversample_filter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module oversample_filter (
	input  logic			data_valid_rdc,
	input  logic			reset_in,
	input  logic			ent_valid,
	input  logic [`N_ADC-1:0]	ent_vec,
	input  logic [`W_DATA-1:0]	ent_a,
	input  logic [`W_DATA-1:0]	ent_b,
	output logic			credit_return,	// one pulse per pop
	output logic			out_valid,
	output logic [`W_CHAN-1:0]	out_chan,
	output adc_pkg::sum_t		out_sum_a,
	output adc_pkg::sum_t		out_sum_b,
	input  logic			out_ready
);
	import adc_pkg::*;

	localparam int W_QP = (`N_CREDITS > 1) ? $clog2(`N_CREDITS) : 1;
	localparam int W_QF = $clog2(`N_CREDITS + 1);
	localparam int W_OSR = (`OSR > 1) ? $clog2(`OSR) : 1;

	// input queue, sized by the credits
	logic [`N_ADC-1:0]	q_vec [`N_CREDITS];
	logic [`W_DATA-1:0]	q_a [`N_CREDITS];
	logic [`W_DATA-1:0]	q_b [`N_CREDITS];
	logic [W_QP-1:0]	q_head;
	logic [W_QP-1:0]	q_tail;
	logic [W_QF-1:0]	q_fill;

	// per channel state
	sum_t			acc_a [`N_ADC];
	sum_t			acc_b [`N_ADC];
	logic [W_OSR-1:0]	cnt [`N_ADC];	// samples already summed

	logic			pop;
	logic			pop_hit;	// head entry has a channel bit
	logic [`W_CHAN-1:0]	pop_chan;
	logic			last;		// pop completes OSR samples
	sum_t			sum_a_nxt;
	sum_t			sum_b_nxt;

	function automatic logic [W_QP-1:0] qp_inc(input logic [W_QP-1:0] p);
		return (p == W_QP'(`N_CREDITS-1)) ? '0 : p + 1'b1;
	endfunction

	// index of the set bit
	function automatic logic [`W_CHAN-1:0] vec_to_chan(input logic [`N_ADC-1:0] vec);
		logic [`W_CHAN-1:0] ch;
		ch = '0;
		for (int i = `N_ADC-1; i >= 0; i--) begin
			if (vec[i])
				ch = `W_CHAN'(i);
		end
		return ch;
	endfunction

	// pop when output reg is free or being taken
	assign pop = (q_fill != '0) && (!out_valid || out_ready);
	assign credit_return = pop;

	assign pop_hit = |q_vec[q_head];
	assign pop_chan = vec_to_chan(q_vec[q_head]);
	assign last = (cnt[pop_chan] == W_OSR'(`OSR-1));
	assign sum_a_nxt = acc_a[pop_chan] + sum_t'(q_a[q_head]);	// zero extended
	assign sum_b_nxt = acc_b[pop_chan] + sum_t'(q_b[q_head]);

	//////////////////////////////
	// input queue
	//////////////////////////////

	always_ff @(posedge data_valid_rdc) begin
		if (ent_valid) begin	// same cycle as the fifo send
			q_vec[q_tail] <= ent_vec;
			q_a[q_tail] <= ent_a;
			q_b[q_tail] <= ent_b;
		end
	end

	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in) begin
			q_head <= '0;
			q_tail <= '0;
			q_fill <= '0;
		end else begin
			if (ent_valid)
				q_tail <= qp_inc(q_tail);
			if (pop)
				q_head <= qp_inc(q_head);
			case ({ent_valid, pop})
				2'b10: q_fill <= q_fill + 1'b1;
				2'b01: q_fill <= q_fill - 1'b1;
				default: ;
			endcase
		end
	end

	//////////////////////////////
	// accumulate and decimate
	//////////////////////////////

	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in) begin
			for (int i = 0; i < `N_ADC; i++) begin
				acc_a[i] <= '0;
				acc_b[i] <= '0;
				cnt[i] <= '0;
			end
			out_valid <= 1'b0;
		end else begin
			if (out_valid && out_ready)
				out_valid <= 1'b0;	// taken
			if (pop && pop_hit) begin
				if (last) begin	// result out, channel starts over
					acc_a[pop_chan] <= '0;
					acc_b[pop_chan] <= '0;
					cnt[pop_chan] <= '0;
					out_valid <= 1'b1;	// wins over the take above
				end else begin
					acc_a[pop_chan] <= sum_a_nxt;
					acc_b[pop_chan] <= sum_b_nxt;
					cnt[pop_chan] <= cnt[pop_chan] + 1'b1;
				end
			end
		end
	end

	// output payload, only loaded while free or being taken
	always_ff @(posedge data_valid_rdc) begin
		if (pop && pop_hit && last) begin
			out_chan <= pop_chan;
			out_sum_a <= sum_a_nxt;
			out_sum_b <= sum_b_nxt;
		end
	end

endmodule

`default_nettype wire

/* rtl/adc_acq_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module adc_acq_top (
	input  logic			data_valid_rdc,	// system clock
	input  logic			reset_in,
	input  logic			adc_sclk,
	input  logic			adc_frame,
	input  logic			adc_sdata_a,
	input  logic			adc_sdata_b,
	output logic			out_valid,
	output logic [`W_CHAN-1:0]	out_chan,
	output adc_pkg::sum_t		out_sum_a,
	output adc_pkg::sum_t		out_sum_b,
	input  logic			out_ready,
	output logic			overflow
);
	// receiver to sync, sclk domain
	logic [`N_ADC-1:0]	data_valid;
	logic [`W_DATA-1:0]	data_a;
	logic [`W_DATA-1:0]	data_b;

	// sync to fifo
	logic			push;
	logic [`N_ADC-1:0]	valid_vec;
	logic [`W_DATA-1:0]	sync_a;
	logic [`W_DATA-1:0]	sync_b;

	// fifo to filter, credit link
	logic			ent_valid;
	logic [`N_ADC-1:0]	ent_vec;
	logic [`W_DATA-1:0]	ent_a;
	logic [`W_DATA-1:0]	ent_b;
	logic			credit_return;

	adc_frame_rx u_rx (
		.adc_sclk(adc_sclk), .reset_in(reset_in), .adc_frame(adc_frame),
		.adc_sdata_a(adc_sdata_a), .adc_sdata_b(adc_sdata_b),
		.data_valid(data_valid), .data_a(data_a), .data_b(data_b)
	);

	adc_clk_sync u_sync (
		.data_valid_rdc(data_valid_rdc), .reset_in(reset_in),
		.data_valid(data_valid), .data_a(data_a), .data_b(data_b),
		.push(push), .valid_vec(valid_vec), .sync_a(sync_a), .sync_b(sync_b)
	);

	sample_fifo u_fifo (
		.data_valid_rdc(data_valid_rdc), .reset_in(reset_in),
		.push(push), .valid_vec(valid_vec), .sync_a(sync_a), .sync_b(sync_b),
		.ent_valid(ent_valid), .ent_vec(ent_vec), .ent_a(ent_a), .ent_b(ent_b),
		.credit_return(credit_return), .overflow(overflow)
	);

	oversample_filter u_filt (
		.data_valid_rdc(data_valid_rdc), .reset_in(reset_in),
		.ent_valid(ent_valid), .ent_vec(ent_vec), .ent_a(ent_a), .ent_b(ent_b),
		.credit_return(credit_return), .out_valid(out_valid), .out_chan(out_chan),
		.out_sum_a(out_sum_a), .out_sum_b(out_sum_b), .out_ready(out_ready)
	);

endmodule

`default_nettype wire

/* testbench/tb_adc_acq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module tb_adc_acq;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int SCLK_NS = 4 * CLK_PERIOD;	// sclk toggles every two system cycles
	localparam int FRAME_BITS = `W_CHAN + `W_DATA;	// channel field then sample field
	localparam int IDLE_SCLK = 6;			// quiet sclk cycles after each frame
	localparam int FRAME_NS = (FRAME_BITS + IDLE_SCLK) * SCLK_NS;
	localparam int N_VALID = 200;
	localparam int N_MIXED = 60;
	localparam int N_RANDOM = 120;
	localparam int N_STALL = 40;
	localparam int N_AFTER = 12;
	localparam int N_FRAMES = N_VALID + N_MIXED + N_RANDOM + N_STALL + N_AFTER;
	localparam int TIMEOUT_NS = N_FRAMES * FRAME_NS * 3;
	localparam int DRAIN_CYCLES = 64;
	localparam int READY_LOW = 0;
	localparam int READY_HIGH = 1;
	localparam int READY_RANDOM = 2;
	localparam logic [31:0] SEED = 32'hc47162ff;

	// dut inputs
	logic			data_valid_rdc = 1'b0;
	logic			reset_in = 1'b1;	// held from time zero
	logic			adc_sclk = 1'b0;
	logic			adc_frame = 1'b0;
	logic			adc_sdata_a = 1'b0;
	logic			adc_sdata_b = 1'b0;
	logic			out_ready = 1'b1;

	// dut outputs
	logic			out_valid;
	logic [`W_CHAN-1:0]	out_chan;
	logic [`W_SUM-1:0]	out_sum_a;
	logic [`W_SUM-1:0]	out_sum_b;
	logic			overflow;

	// reference model partial sums per channel
	logic [`W_SUM-1:0]	acc_a [`N_ADC];
	logic [`W_SUM-1:0]	acc_b [`N_ADC];
	int			acc_n [`N_ADC];
	int			exp_chan [$];	// expected results in completion order
	logic [`W_SUM-1:0]	exp_a [$];
	logic [`W_SUM-1:0]	exp_b [$];
	int			exp_rd = 0;	// next expected result on the monitor side

	logic			sclk_div = 1'b0;
	int			ready_mode = READY_HIGH;
	logic			first_frame_pending = 1'b1;
	logic			ovf_allowed = 1'b0;
	int			checks = 0;	// monitor counters
	int			errors = 0;
	int			seq_checks = 0;	// main sequence counters
	int			seq_errors = 0;
	int			results_seen = 0;
	int			frames_sent = 0;
	int			bad_frames = 0;

	adc_acq_top uut (
		.data_valid_rdc(data_valid_rdc), .reset_in(reset_in), .adc_sclk(adc_sclk),
		.adc_frame(adc_frame), .adc_sdata_a(adc_sdata_a), .adc_sdata_b(adc_sdata_b),
		.out_valid(out_valid), .out_chan(out_chan), .out_sum_a(out_sum_a),
		.out_sum_b(out_sum_b), .out_ready(out_ready), .overflow(overflow)
	);

	always #(CLK_PERIOD/2) data_valid_rdc = ~data_valid_rdc;

	// bit clock of four system cycles per period
	always @(posedge data_valid_rdc) begin
		sclk_div <= ~sclk_div;
		if (sclk_div)
			adc_sclk <= ~adc_sclk;
	end

	always @(posedge data_valid_rdc) begin
		case (ready_mode)
			READY_LOW: out_ready <= 1'b0;
			READY_HIGH: out_ready <= 1'b1;
			default: out_ready <= ($urandom % 2) == 0;	// about half the cycles
		endcase
	end

	//////////////////////////////
	// model and frame driver
	//////////////////////////////

	task automatic clear_model();
		for (int i = 0; i < `N_ADC; i++) begin
			acc_a[i] = '0;
			acc_b[i] = '0;
			acc_n[i] = 0;
		end
	endtask

	task automatic model_frame(input int ch, input logic [`W_DATA-1:0] sa,
			input logic [`W_DATA-1:0] sb);
		if (ch < `N_ADC) begin	// channels 6 and 7 are dropped
			acc_a[ch] = acc_a[ch] + {{(`W_SUM-`W_DATA){1'b0}}, sa};
			acc_b[ch] = acc_b[ch] + {{(`W_SUM-`W_DATA){1'b0}}, sb};
			acc_n[ch]++;
			if (acc_n[ch] == `OSR) begin
				exp_chan.push_back(ch);
				exp_a.push_back(acc_a[ch]);
				exp_b.push_back(acc_b[ch]);
				acc_a[ch] = '0;
				acc_b[ch] = '0;
				acc_n[ch] = 0;
			end
		end
	endtask

	// system edge that takes adc_sclk low half a bit before the sampling edge
	task automatic wait_sclk_fall();
		do begin
			@(posedge data_valid_rdc);
		end while (!(sclk_div && adc_sclk));
	endtask

	task automatic send_frame(input int ch, input logic [`W_DATA-1:0] sa,
			input logic [`W_DATA-1:0] sb);
		logic [`W_CHAN-1:0] ch_bits;
		ch_bits = `W_CHAN'(ch);
		model_frame(ch, sa, sb);
		if (ch >= `N_ADC)
			bad_frames++;
		for (int i = `W_CHAN-1; i >= 0; i--) begin	// msb first
			wait_sclk_fall();
			adc_frame <= (i == `W_CHAN-1);	// marks the first channel bit
			adc_sdata_a <= ch_bits[i];
			adc_sdata_b <= 1'($urandom);	// line b is don't care here
		end
		for (int i = `W_DATA-1; i >= 0; i--) begin
			wait_sclk_fall();
			adc_sdata_a <= sa[i];
			adc_sdata_b <= sb[i];
		end
		first_frame_pending = 1'b0;
		repeat (IDLE_SCLK) begin
			wait_sclk_fall();
			adc_sdata_a <= 1'b0;
			adc_sdata_b <= 1'b0;
		end
		frames_sent++;
	endtask

	task automatic send_random(input int max_chan);
		int ch;
		logic [`W_DATA-1:0] sa;
		logic [`W_DATA-1:0] sb;
		ch = $urandom_range(max_chan, 0);
		sa = `W_DATA'($urandom);
		sb = `W_DATA'($urandom);
		send_frame(ch, sa, sb);
	endtask

	//////////////////////////////
	// checks
	//////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual);
		end
	endtask

	// wait for the output side to catch up with the model
	task automatic drain_results();
		int waited;
		waited = 0;
		while (exp_rd != exp_chan.size() && waited < DRAIN_CYCLES) begin
			@(posedge data_valid_rdc);
			waited++;
		end
		seq_checks++;
		assert (exp_rd == exp_chan.size()) else begin
			seq_errors++;
			$display("error at %0t: %0d expected results never came out",
				$time, exp_chan.size() - exp_rd);
		end
	endtask

	task automatic print_counts();
		$display("checks %0d  errors %0d  results %0d  frames %0d  bad channel frames %0d",
			checks + seq_checks, errors + seq_errors, results_seen, frames_sent, bad_frames);
	endtask

	always @(posedge data_valid_rdc) begin
		if (reset_in) begin
			exp_rd = exp_chan.size();	// pending results are lost to reset
		end else begin
			if (first_frame_pending) begin
				checks++;
				assert (!out_valid && !overflow) else begin
					errors++;
					$display("error at %0t: out_valid or overflow high before any frame",
						$time);
				end
			end
			if (!ovf_allowed) begin
				checks++;
				assert (!overflow) else begin
					errors++;
					$display("[FAIL] %0t overflow expected 0 got 1", $time);
				end
			end
			if (out_valid && out_ready) begin	// handshake taken this edge
				results_seen++;
				checks++;
				assert (exp_rd < exp_chan.size()) else begin
					errors++;
					$display("error at %0t: a result came out with none expected", $time);
				end
				if (exp_rd < exp_chan.size()) begin
					check_value("out_chan", 32'(exp_chan[exp_rd]), 32'(out_chan));
					check_value("out_sum_a", 32'(exp_a[exp_rd]), 32'(out_sum_a));
					check_value("out_sum_b", 32'(exp_b[exp_rd]), 32'(out_sum_b));
					exp_rd++;
				end
			end
		end
	end

	//////////////////////////////
	// sequence
	//////////////////////////////

	initial begin
		void'($urandom(SEED));
		clear_model();
		repeat (RESET_CYCLES) @(posedge data_valid_rdc);
		reset_in <= 1'b0;
		repeat (16) @(posedge data_valid_rdc);	// outputs must stay quiet

		$display("valid channels, out_ready high");
		repeat (N_VALID) send_random(`N_ADC-1);
		drain_results();

		$display("channels 0 to 7 mixed");
		repeat (N_MIXED) send_random((1 << `W_CHAN) - 1);
		drain_results();

		$display("random out_ready");
		ready_mode = READY_RANDOM;
		repeat (N_RANDOM) send_random(`N_ADC-1);
		ready_mode = READY_HIGH;
		drain_results();

		$display("out_ready held low");
		ovf_allowed = 1'b1;
		ready_mode = READY_LOW;
		repeat (N_STALL) send_random(`N_ADC-1);
		@(posedge data_valid_rdc);
		seq_checks++;
		assert (overflow === 1'b1) else begin
			seq_errors++;
			$display("[FAIL] %0t overflow expected 1 got %b", $time, overflow);
		end

		// second reset must clear the sticky flag
		@(posedge data_valid_rdc);
		reset_in <= 1'b1;
		clear_model();
		repeat (RESET_CYCLES) @(posedge data_valid_rdc);
		reset_in <= 1'b0;
		ovf_allowed = 1'b0;
		first_frame_pending = 1'b1;
		ready_mode = READY_HIGH;
		@(posedge data_valid_rdc);
		seq_checks++;
		assert (overflow === 1'b0) else begin
			seq_errors++;
			$display("[FAIL] %0t overflow expected 0 got %b", $time, overflow);
		end
		repeat (N_AFTER) send_random(`N_ADC-1);
		drain_results();

		print_counts();
		if (errors + seq_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// watchdog at three times the nominal frame time
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
		print_counts();
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/adc_pkg.sv
rtl/adc_frame_rx.sv
rtl/adc_clk_sync.sv
rtl/sample_fifo.sv
rtl/oversample_filter.sv
rtl/adc_acq_top.sv
testbench/tb_adc_acq.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP ?= tb_adc_acq
RTL_TOP ?= adc_acq_top
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= All checks passed

SOURCES := $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
